// File: compile.f
verilog/chitchat_pkg.sv
verilog/chitchat_status_pkg.sv
verilog/crc16.sv
verilog/chitchat_tx.sv
verilog/chitchat_rx.sv
verilog/chitchat_link_monitor.sv
verilog/chitchat_link.sv
testbench/tb_clock.sv
testbench/chitchat_link_assert.sv
testbench/chitchat_link_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module chitchat_link_tb -o Vtb
	./obj_dir/Vtb > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/chitchat_link_tb.sv
// Loopback testbench of the link top level
// Fault-injection path, directed tests, value check, result counts
`timescale 1ns/1ns
`default_nettype none

module chitchat_link_tb;

  import chitchat_status_pkg::*;

  localparam logic [31:0] REV_ID       = 32'hC0DE_0517;
  localparam logic [2:0]  TX_GW_TYPE   = 3'd5;
  localparam int          LINK_UP_CNT  = 4;
  localparam int          LINK_TIMEOUT = 64;

  logic         clk;
  logic         rst_n;
  logic         tx_transmit_en;
  logic [2:0]   tx_location;
  logic [31:0]  tx_data0;
  logic [31:0]  tx_data1;
  logic [127:0] tx_extra_data;
  wire          tx_send;
  wire  [15:0]  gtx_tx_d;
  wire  [1:0]   gtx_tx_k;
  logic [15:0]  gtx_rx_d = 16'd0;
  logic [1:0]   gtx_rx_k = 2'b00;
  wire          rx_valid;
  wire          rx_fault_strobe;
  fault_t       rx_fault;
  wire  [2:0]   rx_location;
  wire  [2:0]   rx_gateware_type;
  wire  [31:0]  rx_rev_id;
  wire  [31:0]  rx_data0;
  wire  [31:0]  rx_data1;
  wire  [15:0]  rx_frame_counter;
  wire  [15:0]  rx_extra_word;
  wire  [2:0]   rx_extra_index;
  wire          link_up;
  wire  [15:0]  round_trip;
  wire  [15:0]  fault_count;

  int pass_count;
  int fail_count;
  int test_fails;

  tb_clock clk0 (.clk(clk), .rst_n(rst_n));

  chitchat_link #(
    .REV_ID           (REV_ID),
    .TX_GATEWARE_TYPE (TX_GW_TYPE),
    .LINK_UP_CNT      (LINK_UP_CNT),
    .LINK_TIMEOUT     (LINK_TIMEOUT)
  ) dut0 (
    .clk(clk), .rst_n(rst_n), .tx_transmit_en(tx_transmit_en),
    .tx_location(tx_location), .tx_data0(tx_data0), .tx_data1(tx_data1),
    .tx_extra_data(tx_extra_data), .tx_send(tx_send), .gtx_tx_d(gtx_tx_d),
    .gtx_tx_k(gtx_tx_k), .gtx_rx_d(gtx_rx_d), .gtx_rx_k(gtx_rx_k),
    .rx_valid(rx_valid), .rx_fault_strobe(rx_fault_strobe), .rx_fault(rx_fault),
    .rx_location(rx_location), .rx_gateware_type(rx_gateware_type),
    .rx_rev_id(rx_rev_id), .rx_data0(rx_data0), .rx_data1(rx_data1),
    .rx_frame_counter(rx_frame_counter), .rx_extra_word(rx_extra_word),
    .rx_extra_index(rx_extra_index), .link_up(link_up), .round_trip(round_trip),
    .fault_count(fault_count)
  );

  // ----------------------------------------------------------------------
  // Loopback register with CRC corruption
  // ----------------------------------------------------------------------
  logic       corrupt_req;
  logic [3:0] sym_pos;
  int         corrupt_applied;

  always @(posedge clk) begin
    if (!rst_n) begin
      gtx_rx_d        <= 16'd0;
      gtx_rx_k        <= 2'b00;
      sym_pos         <= 4'd0;
      corrupt_applied <= 0;
    end else begin
      gtx_rx_k <= gtx_tx_k;
      // Symbol 11 after the comma is the CRC
      if (corrupt_req && sym_pos == 4'd11 && !gtx_tx_k[0]) begin
        gtx_rx_d        <= gtx_tx_d ^ 16'h0001;
        corrupt_applied <= corrupt_applied + 1;
      end else begin
        gtx_rx_d <= gtx_tx_d;
      end
      if (gtx_tx_k[0]) sym_pos <= 4'd1;
      else if (sym_pos == 4'd11) sym_pos <= 4'd0;
      else if (sym_pos != 4'd0) sym_pos <= sym_pos + 4'd1;
    end
  end

  // ----------------------------------------------------------------------
  // Round-trip reference from the line
  // ----------------------------------------------------------------------
  logic [15:0] sends_seen;
  logic [15:0] echo_seen;

  // Frames announced so far and the echo word of the latest frame on the line
  always @(posedge clk) begin
    if (!rst_n) begin
      sends_seen <= 16'd0;
      echo_seen  <= 16'd0;
    end else begin
      if (tx_send) sends_seen <= sends_seen + 16'd1;
      if (sym_pos == 4'd9 && !gtx_tx_k[0]) echo_seen <= gtx_tx_d;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic expect_equal(input string msg, input logic [127:0] exp,
                              input logic [127:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t: %s expected %h got %h", $time, msg, exp, act);
      fail_count++;
      test_fails++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%0t: %s", $time, msg);
    fail_count++;
    test_fails++;
  endtask

  // Step one cycle and sample 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Next frame strobe of either kind within 40 cycles
  task automatic wait_frame(output logic got_valid, output logic got_fault);
    int n;
    got_valid = 1'b0;
    got_fault = 1'b0;
    for (n = 0; n < 40; n++) begin
      next_cycle();
      if (rx_valid || rx_fault_strobe) begin
        got_valid = rx_valid;
        got_fault = rx_fault_strobe;
        break;
      end
    end
    if (!got_valid && !got_fault) report_failure("timeout while waiting for a received frame");
  endtask

  task automatic report_test(input string name);
    $display("test %s done with %0d mismatches", name, test_fails);
    test_fails = 0;
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic idle_after_reset();
    int n;
    for (n = 0; n < 30; n++) begin
      next_cycle();
      expect_equal("tx_send idle", 1'b0, tx_send);
      expect_equal("rx_valid idle", 1'b0, rx_valid);
      expect_equal("link_up idle", 1'b0, link_up);
      expect_equal("gtx_tx_k idle", 2'b00, gtx_tx_k);
    end
    report_test("reset");
  endtask

  task automatic frame_counters();
    logic v;
    logic f;
    logic [15:0] prev_cnt;
    logic [15:0] exp_rt;
    int k;
    tx_transmit_en = 1'b1;
    for (k = 1; k <= LINK_UP_CNT + 4; k++) begin
      expect_equal("link_up before good frame", (k > LINK_UP_CNT) ? 1'b1 : 1'b0, link_up);
      wait_frame(v, f);
      expect_equal("good frame", 1'b1, v);
      if (k > 1) expect_equal("frame counter step", prev_cnt + 16'd1, rx_frame_counter);
      prev_cnt = rx_frame_counter;
      // Frames sent so far minus the count this frame echoed
      exp_rt = sends_seen - echo_seen;
      next_cycle();
      expect_equal("round_trip", exp_rt, round_trip);
      if (k == LINK_UP_CNT) expect_equal("link_up after count", 1'b1, link_up);
    end
    report_test("counters");
  endtask

  task automatic data_transfer();
    logic v;
    logic f;
    int k;
    tx_data0    = $urandom;
    tx_data1    = $urandom;
    tx_location = 3'($urandom);
    // Frames already in flight carry old data
    for (k = 0; k < 3; k++) wait_frame(v, f);
    for (k = 0; k < 5; k++) begin
      wait_frame(v, f);
      expect_equal("good frame", 1'b1, v);
      expect_equal("rx_data0", tx_data0, rx_data0);
      expect_equal("rx_data1", tx_data1, rx_data1);
      expect_equal("rx_location", tx_location, rx_location);
      expect_equal("rx_rev_id", REV_ID, rx_rev_id);
      expect_equal("rx_gateware_type", TX_GW_TYPE, rx_gateware_type);
    end
    report_test("data");
  endtask

  task automatic extra_slices();
    logic v;
    logic f;
    int k;
    tx_extra_data = {$urandom, $urandom, $urandom, $urandom};
    // Wait for a fresh snapshot at slice 0 plus the pipeline
    for (k = 0; k < 10; k++) wait_frame(v, f);
    for (k = 0; k < 8; k++) begin
      wait_frame(v, f);
      expect_equal("good frame", 1'b1, v);
      expect_equal("rx_extra_index", rx_frame_counter[2:0], rx_extra_index);
      expect_equal("rx_extra_word", tx_extra_data[rx_extra_index * 16 +: 16], rx_extra_word);
    end
    report_test("extra");
  endtask

  task automatic crc_fault_recovery();
    logic v;
    logic f;
    logic [15:0] old_faults;
    int k;
    expect_equal("link_up before fault", 1'b1, link_up);
    old_faults = fault_count;
    k = corrupt_applied;
    corrupt_req = 1'b1;
    wait_frame(v, f);
    if (!f) wait_frame(v, f);
    corrupt_req = 1'b0;
    expect_equal("fault strobe", 1'b1, f);
    expect_equal("fault cause", FAULT_CRC_BAD, rx_fault);
    expect_equal("one corrupted symbol", k + 1, corrupt_applied);
    next_cycle();
    expect_equal("link_up after fault", 1'b0, link_up);
    expect_equal("fault_count", old_faults + 16'd1, fault_count);
    for (k = 0; k < LINK_UP_CNT; k++) begin
      expect_equal("link_up during recovery", 1'b0, link_up);
      wait_frame(v, f);
      expect_equal("clean frame", 1'b1, v);
    end
    next_cycle();
    expect_equal("link_up recovered", 1'b1, link_up);
    report_test("crc_fault");
  endtask

  task automatic silence_timeout();
    int n;
    tx_transmit_en = 1'b0;
    n = 0;
    while (link_up && n < LINK_TIMEOUT + 20) begin
      next_cycle();
      n++;
      // A start decided just before the drop may still show in the first cycle
      if (n > 1) expect_equal("no tx_send when disabled", 1'b0, tx_send);
    end
    if (link_up) begin
      report_failure("link_up did not fall within the limit after the link went silent");
    end else if (n < LINK_TIMEOUT) begin
      report_failure("link_up fell too early after the link went silent");
    end
    report_test("silence");
  endtask

  initial begin
    int n;
    tx_transmit_en = 1'b0;
    tx_location    = 3'd0;
    tx_data0       = 32'd0;
    tx_data1       = 32'd0;
    tx_extra_data  = 128'd0;
    corrupt_req    = 1'b0;
    pass_count     = 0;
    fail_count     = 0;
    test_fails     = 0;
    void'($urandom(32'h1568));
    for (n = 0; n < 20 && rst_n !== 1'b1; n++) @(posedge clk);
    if (rst_n !== 1'b1) report_failure("reset was never released");
    #1;
    idle_after_reset();
    frame_counters();
    data_transfer();
    extra_slices();
    crc_fault_recovery();
    silence_timeout();
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/chitchat_link_assert.sv
// Concurrent protocol checks on the link top level
// Strobe exclusion, frame spacing, link-up cause
`timescale 1ns/1ns
`default_nettype none

module chitchat_link_assert (
  input wire clk,
  input wire rst_n,
  input wire tx_send,
  input wire rx_valid,
  input wire rx_fault_strobe,
  input wire link_up
);

  // Good and bad frame strobes exclude each other
  strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rx_valid && rx_fault_strobe))
    else $error("rx_valid and rx_fault_strobe high together");

  // Frames start at least 12 cycles apart
  send_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    tx_send |=> !tx_send [*11])
    else $error("tx_send repeated within a frame");

  // Link only comes up on a good frame
  link_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(link_up) |-> $past(rx_valid))
    else $error("link_up rose without rx_valid");

endmodule

bind chitchat_link chitchat_link_assert a0 (
  .clk             (clk),
  .rst_n           (rst_n),
  .tx_send         (tx_send),
  .rx_valid        (rx_valid),
  .rx_fault_strobe (rx_fault_strobe),
  .link_up         (link_up)
);

`default_nettype wire

// File: testbench/tb_clock.sv
// Testbench clock and reset source
// 100 ns period, reset held low for 5 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Release 1 ns after the fifth rising edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verilog/chitchat_link.sv
// Top level of one link end
// Framer, deframer and link monitor
`timescale 1ns/1ns
`default_nettype none

module chitchat_link #(
  parameter logic [31:0] REV_ID           = 32'h0001_0203,
  parameter logic [2:0]  TX_GATEWARE_TYPE = 3'd2,
  parameter int          LINK_UP_CNT      = 4,
  parameter int          LINK_TIMEOUT     = 64
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          tx_transmit_en,
  input  wire  [2:0]                   tx_location,
  input  wire  [31:0]                  tx_data0,
  input  wire  [31:0]                  tx_data1,
  input  wire  [127:0]                 tx_extra_data,
  output wire                          tx_send,
  output wire  [15:0]                  gtx_tx_d,
  output wire  [1:0]                   gtx_tx_k,
  input  wire  [15:0]                  gtx_rx_d,
  input  wire  [1:0]                   gtx_rx_k,
  output wire                          rx_valid,
  output wire                          rx_fault_strobe,
  output chitchat_status_pkg::fault_t  rx_fault,
  output wire  [2:0]                   rx_location,
  output wire  [2:0]                   rx_gateware_type,
  output wire  [31:0]                  rx_rev_id,
  output wire  [31:0]                  rx_data0,
  output wire  [31:0]                  rx_data1,
  output wire  [15:0]                  rx_frame_counter,
  output wire  [15:0]                  rx_extra_word,
  output wire  [2:0]                   rx_extra_index,
  output wire                          link_up,
  output wire  [15:0]                  round_trip,
  output wire  [15:0]                  fault_count
);

  wire [15:0] local_frame_counter;
  wire [15:0] rx_loopback_frame_counter;

  // Far end frame counter goes back out in every frame
  chitchat_tx #(
    .REV_ID           (REV_ID),
    .TX_GATEWARE_TYPE (TX_GATEWARE_TYPE)
  ) tx0 (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .tx_transmit_en            (tx_transmit_en),
    .tx_location               (tx_location),
    .tx_data0                  (tx_data0),
    .tx_data1                  (tx_data1),
    .tx_extra_data             (tx_extra_data),
    .tx_loopback_frame_counter (rx_frame_counter),
    .tx_send                   (tx_send),
    .local_frame_counter       (local_frame_counter),
    .gtx_d                     (gtx_tx_d),
    .gtx_k                     (gtx_tx_k)
  );

  chitchat_rx rx0 (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .gtx_d                     (gtx_rx_d),
    .gtx_k                     (gtx_rx_k),
    .rx_valid                  (rx_valid),
    .rx_fault_strobe           (rx_fault_strobe),
    .rx_fault                  (rx_fault),
    .rx_location               (rx_location),
    .rx_gateware_type          (rx_gateware_type),
    .rx_rev_id                 (rx_rev_id),
    .rx_data0                  (rx_data0),
    .rx_data1                  (rx_data1),
    .rx_frame_counter          (rx_frame_counter),
    .rx_loopback_frame_counter (rx_loopback_frame_counter),
    .rx_extra_word             (rx_extra_word),
    .rx_extra_index            (rx_extra_index)
  );

  // Round trip from the local count and its echo
  chitchat_link_monitor #(
    .LINK_UP_CNT  (LINK_UP_CNT),
    .LINK_TIMEOUT (LINK_TIMEOUT)
  ) mon0 (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .rx_valid                  (rx_valid),
    .rx_fault_strobe           (rx_fault_strobe),
    .local_frame_counter       (local_frame_counter),
    .rx_loopback_frame_counter (rx_loopback_frame_counter),
    .link_up                   (link_up),
    .round_trip                (round_trip),
    .fault_count               (fault_count)
  );

endmodule

`default_nettype wire

// File: verilog/chitchat_link_monitor.sv
// Link monitor
// Link-up count, silence timeout, round trip in frames, fault count
`timescale 1ns/1ns
`default_nettype none

module chitchat_link_monitor #(
  parameter int LINK_UP_CNT  = 4,
  parameter int LINK_TIMEOUT = 64
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         rx_valid,
  input  wire         rx_fault_strobe,
  input  wire  [15:0] local_frame_counter,
  input  wire  [15:0] rx_loopback_frame_counter,
  output logic        link_up,
  output logic [15:0] round_trip,
  output logic [15:0] fault_count
);

  localparam int GW = $clog2(LINK_UP_CNT + 1);
  localparam int IW = $clog2(LINK_TIMEOUT + 1);

  logic [GW-1:0] good_cnt;
  logic [IW-1:0] idle_cnt;
  logic          timeout;

  // LINK_TIMEOUT cycles without a good frame
  assign timeout = !rx_valid && (idle_cnt == IW'(LINK_TIMEOUT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      good_cnt    <= '0;
      idle_cnt    <= '0;
      link_up     <= 1'b0;
      round_trip  <= 16'd0;
      fault_count <= 16'd0;
    end else begin
      // Idle counter saturates at the limit
      if (rx_valid) begin
        idle_cnt <= '0;
      end else if (idle_cnt != IW'(LINK_TIMEOUT)) begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      if (rx_fault_strobe || timeout) begin
        // Any fault or silence restarts the good-frame count
        good_cnt <= '0;
        link_up  <= 1'b0;
      end else if (rx_valid) begin
        if (good_cnt != GW'(LINK_UP_CNT)) begin
          good_cnt <= good_cnt + 1'b1;
        end
        if (good_cnt == GW'(LINK_UP_CNT - 1)) begin
          link_up <= 1'b1;
        end
      end
      // Local count minus the echo of it, wraps modulo 2^16
      if (rx_valid) begin
        round_trip <= local_frame_counter - rx_loopback_frame_counter;
      end
      if (rx_fault_strobe && fault_count != 16'hFFFF) begin
        fault_count <= fault_count + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/chitchat_rx.sv
// Deframer of the link
// Comma alignment, word capture, CRC and header check, decoded-field strobe
`timescale 1ns/1ns
`default_nettype none

module chitchat_rx (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire  [15:0]                  gtx_d,
  input  wire  [1:0]                   gtx_k,
  output logic                         rx_valid,
  output logic                         rx_fault_strobe,
  output chitchat_status_pkg::fault_t  rx_fault,
  output logic [2:0]                   rx_location,
  output logic [2:0]                   rx_gateware_type,
  output logic [31:0]                  rx_rev_id,
  output logic [31:0]                  rx_data0,
  output logic [31:0]                  rx_data1,
  output logic [15:0]                  rx_frame_counter,
  output logic [15:0]                  rx_loopback_frame_counter,
  output logic [15:0]                  rx_extra_word,
  output logic [2:0]                   rx_extra_index
);

  import chitchat_pkg::*;
  import chitchat_status_pkg::*;

  rx_state_t   state;
  // Words taken since the comma, minus one
  logic [3:0]  word_cnt;
  logic [15:0] cap [FRAME_WORDS];
  logic [15:0] crc_rx;
  logic [15:0] crc_hold;
  logic        comma;
  logic        crc_zero;
  logic        last_word;
  logic        crc_ok;
  logic        proto_ok;

  assign comma     = gtx_k[0] && (gtx_d[7:0] == CC_K28_5);
  // First data word restarts the checksum
  assign crc_zero  = (state == RX_COLLECT) && (word_cnt == 4'd0);
  // CRC word on the line
  assign last_word = (state == RX_COLLECT) && (word_cnt == 4'(W_CRC - 1));

  crc16 crc_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .zero  (crc_zero),
    .din   (gtx_d),
    .crc   (crc_rx)
  );

  // ----------------------------------------------------------------------
  // Capture, the comma word settles at index 0 in CHECK
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < FRAME_WORDS - 1; i++) begin
      cap[i] <= cap[i + 1];
    end
    cap[FRAME_WORDS - 1] <= gtx_d;
    // Sum of words 1 to 10, before the CRC word itself goes in
    if (last_word) begin
      crc_hold <= crc_rx;
    end
  end

  assign crc_ok   = (cap[W_CRC] == crc_hold);
  assign proto_ok = (cap[W_HEADER][15:8] == {CC_PROTOCOL_CAT, CC_PROTOCOL_VER});

  // ----------------------------------------------------------------------
  // FSM and strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state                     <= RX_HUNT;
      word_cnt                  <= 4'd0;
      rx_valid                  <= 1'b0;
      rx_fault_strobe           <= 1'b0;
      rx_fault                  <= FAULT_NONE;
      rx_frame_counter          <= 16'd0;
      rx_loopback_frame_counter <= 16'd0;
    end else begin
      rx_valid        <= 1'b0;
      rx_fault_strobe <= 1'b0;
      case (state)
        RX_HUNT: begin
          if (comma) begin
            state    <= RX_COLLECT;
            word_cnt <= 4'd0;
          end
        end
        RX_COLLECT: begin
          if (comma) begin
            // Comma too early, the new one starts a fresh frame
            rx_fault_strobe <= 1'b1;
            rx_fault        <= FAULT_SHORT_FRAME;
            word_cnt        <= 4'd0;
          end else if (last_word) begin
            state <= RX_CHECK;
          end else begin
            word_cnt <= word_cnt + 4'd1;
          end
        end
        RX_CHECK: begin
          // Back-to-back frames put the next comma in this cycle
          state    <= comma ? RX_COLLECT : RX_HUNT;
          word_cnt <= 4'd0;
          if (!crc_ok) begin
            rx_fault_strobe <= 1'b1;
            rx_fault        <= FAULT_CRC_BAD;
          end else if (!proto_ok) begin
            rx_fault_strobe <= 1'b1;
            rx_fault        <= FAULT_PROTO_BAD;
          end else begin
            rx_valid                  <= 1'b1;
            rx_fault                  <= FAULT_NONE;
            rx_frame_counter          <= cap[W_FRAME_CNT];
            rx_loopback_frame_counter <= cap[W_LOOP_CNT];
          end
        end
        default: state <= RX_HUNT;
      endcase
    end
  end

  // Decoded payload, held until the next good frame
  always_ff @(posedge clk) begin
    if (state == RX_CHECK && crc_ok && proto_ok) begin
      rx_gateware_type <= cap[W_TYPE_LOC][15:13];
      rx_location      <= cap[W_TYPE_LOC][12:10];
      rx_rev_id        <= {cap[W_REV_HI], cap[W_REV_LO]};
      rx_data0         <= {cap[W_DATA0_HI], cap[W_DATA0_LO]};
      rx_data1         <= {cap[W_DATA1_HI], cap[W_DATA1_LO]};
      rx_extra_word    <= cap[W_EXTRA];
      // Slice number follows the sender's frame counter
      rx_extra_index   <= cap[W_FRAME_CNT][2:0];
    end
  end

endmodule

`default_nettype wire

// File: verilog/chitchat_tx.sv
// Periodic framer of the link
// Frame timing, 12-word shift register, extra-data slicing, CRC insertion
`timescale 1ns/1ns
`default_nettype none

module chitchat_tx #(
  parameter logic [31:0] REV_ID           = 32'h0000_0000,
  parameter logic [2:0]  TX_GATEWARE_TYPE = 3'd0
) (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          tx_transmit_en,
  input  wire  [2:0]   tx_location,
  input  wire  [31:0]  tx_data0,
  input  wire  [31:0]  tx_data1,
  input  wire  [127:0] tx_extra_data,
  input  wire  [15:0]  tx_loopback_frame_counter,
  output logic         tx_send,
  output logic [15:0]  local_frame_counter,
  output logic [15:0]  gtx_d,
  output logic [1:0]   gtx_k
);

  import chitchat_pkg::*;

  // ----------------------------------------------------------------------
  // Frame timing
  // ----------------------------------------------------------------------
  logic [3:0] word_count;
  logic       increment;
  logic       start;
  logic       sync;
  logic       sync_r;
  logic       last;
  logic       last_r;
  logic       crc_time;

  // Once started the count runs to the end, so a frame always completes
  assign increment = tx_transmit_en | (word_count != 4'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_count <= 4'd0;
      start      <= 1'b0;
      sync       <= 1'b0;
      sync_r     <= 1'b0;
      last       <= 1'b0;
      last_r     <= 1'b0;
      crc_time   <= 1'b0;
    end else begin
      word_count <= (word_count == 4'(FRAME_WORDS - 1)) ? 4'd0 : word_count + 4'(increment);
      // Load pulse, one per 12 cycles
      start      <= (word_count == 4'd1);
      // Comma word at the head of the shift register
      sync       <= start;
      // First CRC word at the head
      sync_r     <= sync;
      last       <= (word_count == 4'(FRAME_WORDS - 1));
      last_r     <= last;
      // Pad word at the head, swap in the CRC
      crc_time   <= last_r;
    end
  end

  // ----------------------------------------------------------------------
  // Frame counter and extra-data slice
  // ----------------------------------------------------------------------
  logic [15:0]  frame_counter;
  logic [127:0] extra_hold;
  logic [15:0]  extra_word;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_counter <= 16'd0;
    end else begin
      frame_counter <= frame_counter + 16'(start);
    end
  end

  // Block is frozen at slice 0 so all eight slices come from one snapshot
  always_ff @(posedge clk) begin
    if (frame_counter[2:0] == 3'd0) begin
      extra_hold <= tx_extra_data;
      extra_word <= tx_extra_data[15:0];
    end else begin
      extra_word <= extra_hold[{frame_counter[2:0], 4'b0000} +: 16];
    end
  end

  // ----------------------------------------------------------------------
  // Frame shift register, parallel load on start
  // ----------------------------------------------------------------------
  logic [15:0] frame [FRAME_WORDS];

  always_ff @(posedge clk) begin
    if (start) begin
      frame[W_HEADER]    <= {CC_PROTOCOL_CAT, CC_PROTOCOL_VER, CC_K28_5};
      frame[W_TYPE_LOC]  <= {TX_GATEWARE_TYPE, tx_location, 10'd0};
      frame[W_REV_HI]    <= REV_ID[31:16];
      frame[W_REV_LO]    <= REV_ID[15:0];
      frame[W_DATA0_HI]  <= tx_data0[31:16];
      frame[W_DATA0_LO]  <= tx_data0[15:0];
      frame[W_DATA1_HI]  <= tx_data1[31:16];
      frame[W_DATA1_LO]  <= tx_data1[15:0];
      frame[W_FRAME_CNT] <= frame_counter;
      frame[W_LOOP_CNT]  <= tx_loopback_frame_counter;
      frame[W_EXTRA]     <= extra_word;
      // Pad, replaced by the CRC on the way out
      frame[W_CRC]       <= 16'h0000;
    end else begin
      for (int i = 0; i < FRAME_WORDS - 1; i++) begin
        frame[i] <= frame[i + 1];
      end
      frame[FRAME_WORDS - 1] <= 16'h0000;
    end
  end

  // ----------------------------------------------------------------------
  // CRC and output registers
  // ----------------------------------------------------------------------
  logic [15:0] crc_tx;
  logic [15:0] pre_d;
  logic        pre_k;

  crc16 crc_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .zero  (sync_r),
    .din   (frame[0]),
    .crc   (crc_tx)
  );

  always_ff @(posedge clk) begin
    pre_d <= crc_time ? crc_tx : frame[0];
    gtx_d <= pre_d;
  end

  // Comma flag in the low byte only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pre_k <= 1'b0;
      gtx_k <= 2'b00;
    end else begin
      pre_k <= sync;
      gtx_k <= {1'b0, pre_k};
    end
  end

  assign tx_send             = start;
  assign local_frame_counter = frame_counter;

endmodule

`default_nettype wire

// File: verilog/crc16.sv
// CRC-16/CCITT over one 16-bit word per cycle
// zero restarts the sum from the seed with the current word
`timescale 1ns/1ns
`default_nettype none

module crc16 (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         zero,
  input  wire  [15:0] din,
  output logic [15:0] crc
);

  localparam logic [15:0] CRC_POLY = 16'h1021;
  localparam logic [15:0] CRC_SEED = 16'hFFFF;

  // Sixteen serial steps, MSB of the word first
  function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [15:0] d);
    logic [15:0] r;
    r = c;
    for (int i = 15; i >= 0; i--) begin
      if (r[15] ^ d[i]) begin
        r = {r[14:0], 1'b0} ^ CRC_POLY;
      end else begin
        r = {r[14:0], 1'b0};
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crc <= CRC_SEED;
    end else begin
      // Seed replaces the running sum on the first word of a frame
      crc <= crc_step(zero ? CRC_SEED : crc, din);
    end
  end

endmodule

`default_nettype wire

// File: verilog/chitchat_status_pkg.sv
// Receiver state and fault cause encodings
// Shared by deframer, link monitor and testbench
`default_nettype none

package chitchat_status_pkg;

  // Deframer FSM
  typedef enum logic [1:0] {
    // Waiting for a comma
    RX_HUNT    = 2'd0,
    // Taking the 11 words after the comma
    RX_COLLECT = 2'd1,
    // CRC and header check, one cycle
    RX_CHECK   = 2'd2
  } rx_state_t;

  // Reason for the last rejected frame
  typedef enum logic [1:0] {
    FAULT_NONE        = 2'd0,
    // Received CRC word differs from the recomputed one
    FAULT_CRC_BAD     = 2'd1,
    // Category or version mismatch in the header
    FAULT_PROTO_BAD   = 2'd2,
    // Comma seen before the frame was complete
    FAULT_SHORT_FRAME = 2'd3
  } fault_t;

endpackage

`default_nettype wire

// File: verilog/chitchat_pkg.sv
// Frame format of the inter-chassis link
// Word count, comma code, protocol identifiers, field positions
`default_nettype none

package chitchat_pkg;

  // Symbols per frame, comma word included
  localparam int FRAME_WORDS = 12;

  // ----------------------------------------------------------------------
  // Header contents
  // ----------------------------------------------------------------------
  // K28.5 comma, sent in the low byte with gtx_k[0] set
  localparam logic [7:0] CC_K28_5 = 8'hBC;

  // Upper byte of the comma word
  localparam logic [3:0] CC_PROTOCOL_CAT = 4'h1;
  localparam logic [3:0] CC_PROTOCOL_VER = 4'h1;

  // ----------------------------------------------------------------------
  // Word positions, index 0 goes on the line first
  // ----------------------------------------------------------------------
  localparam int W_HEADER    = 0;
  // Gateware type, location, 10 reserved bits
  localparam int W_TYPE_LOC  = 1;
  localparam int W_REV_HI    = 2;
  localparam int W_REV_LO    = 3;
  // 32-bit data travels big-endian
  localparam int W_DATA0_HI  = 4;
  localparam int W_DATA0_LO  = 5;
  localparam int W_DATA1_HI  = 6;
  localparam int W_DATA1_LO  = 7;
  localparam int W_FRAME_CNT = 8;
  // Far end counter echoed back
  localparam int W_LOOP_CNT  = 9;
  localparam int W_EXTRA     = 10;
  // CRC over words 1 to 10
  localparam int W_CRC       = 11;

endpackage

`default_nettype wire
